// ==== gaussian_accel_top.sv ====
// gaussian blur accelerator top

`timescale 1ns/1ps
`default_nettype none

`include "gaussian_settings.svh"

module gaussian_accel_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start_req,
  input  gaussian_pkg::t_job_desc job_in,
  input  host_if_pkg::t_mem_rsp   rsp,
  input  host_if_pkg::t_mem_flow  flow,
  output logic                    start_ack,
  output host_if_pkg::t_rd_req    rd_req,
  output host_if_pkg::t_wr_req    wr_req
);

  logic                    go;
  logic                    done;
  gaussian_pkg::t_job_desc job;
  host_if_pkg::t_line_data line_in;
  logic                    line_valid;
  host_if_pkg::t_line_data filt_line;
  logic                    filt_valid;

  gaussian_job_ctrl u_job_ctrl (
    .clk       (clk),
    .reset     (reset),
    .start_req (start_req),
    .job_in    (job_in),
    .done      (done),
    .start_ack (start_ack),
    .go        (go),
    .job       (job)
  );

  gaussian_requestor u_requestor (
    .clk        (clk),
    .reset      (reset),
    .go         (go),
    .job        (job),
    .rsp        (rsp),
    .flow       (flow),
    .filt_line  (filt_line),
    .filt_valid (filt_valid),
    .rd_req     (rd_req),
    .wr_req     (wr_req),
    .line_out   (line_in),
    .line_valid (line_valid),
    .done       (done)
  );

  gaussian_line_filter u_line_filter (
    .clk        (clk),
    .reset      (reset),
    .line_in    (line_in),
    .line_valid (line_valid),
    .line_out   (filt_line),
    .out_valid  (filt_valid)
  );

endmodule : gaussian_accel_top

`default_nettype wire

// ==== gaussian_job_ctrl.sv ====
// job start handshake

`timescale 1ns/1ps
`default_nettype none

`include "gaussian_settings.svh"

module gaussian_job_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start_req,
  input  gaussian_pkg::t_job_desc job_in,
  input  logic                   done,
  output logic                   start_ack,
  output logic                   go,
  output gaussian_pkg::t_job_desc job
);

  typedef enum logic [1:0] {
    js_idle,
    js_busy,
    js_ack
  } t_ctrl_state;

  t_ctrl_state state;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= js_idle;
      go        <= 1'b0;
      start_ack <= 1'b0;
    end else begin
      go <= 1'b0;
      case (state)
        js_idle: begin
          if (start_req) begin
            go    <= 1'b1;              // one cycle pulse
            state <= js_busy;
          end
        end
        js_busy: begin
          if (done) begin
            start_ack <= 1'b1;
            state     <= js_ack;
          end
        end
        js_ack: begin
          if (!start_req) begin         // host has seen the ack
            start_ack <= 1'b0;
            state     <= js_idle;
          end
        end
        default: state <= js_idle;
      endcase
    end
  end

  // descriptor held for the whole job
  always_ff @(posedge clk) begin
    if (state == js_idle && start_req) begin
      job <= job_in;
    end
  end

endmodule : gaussian_job_ctrl

`default_nettype wire

// ==== gaussian_line_filter.sv ====
// horizontal 1-2-1 line filter

`timescale 1ns/1ps
`default_nettype none

`include "gaussian_settings.svh"

module gaussian_line_filter (
  input  logic                    clk,
  input  logic                    reset,
  input  host_if_pkg::t_line_data line_in,
  input  logic                    line_valid,
  output host_if_pkg::t_line_data line_out,
  output logic                    out_valid
);

  localparam int unsigned NPIX = gaussian_pkg::PIX_PER_LINE;

  typedef logic [`GAUSS_PIX_BITS+1:0] t_tap_sum;   // room for 4x a pixel

  gaussian_pkg::t_pix_line pix_in;
  gaussian_pkg::t_pix_line pix_out;
  t_tap_sum                sum_d [NPIX];
  t_tap_sum                sum_q [NPIX];
  logic                    s1_valid;

  // ####################################################################
  // stage one: neighbour sums with edge replication
  // ####################################################################

  always_comb begin
    int left_idx;
    int right_idx;
    pix_in = gaussian_pkg::t_pix_line'(line_in);
    for (int i = 0; i < NPIX; i++) begin
      left_idx  = (i == 0) ? 0 : i - 1;
      right_idx = (i == NPIX - 1) ? NPIX - 1 : i + 1;
      sum_d[i]  = t_tap_sum'(pix_in[left_idx]) + (t_tap_sum'(pix_in[i]) << 1) +
                  t_tap_sum'(pix_in[right_idx]);
    end
  end

  always_ff @(posedge clk) begin
    if (line_valid) begin
      sum_q <= sum_d;
    end
  end

  // ####################################################################
  // stage two: divide by four and pack
  // ####################################################################

  always_comb begin
    for (int i = 0; i < NPIX; i++) begin
      pix_out[i] = sum_q[i][`GAUSS_PIX_BITS+1:2];   // truncating shift
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      line_out <= host_if_pkg::t_line_data'(pix_out);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= line_valid;
      out_valid <= s1_valid;
    end
  end

endmodule : gaussian_line_filter

`default_nettype wire

// ==== gaussian_pkg.sv ====
// gaussian accelerator types

`default_nettype none

`include "gaussian_settings.svh"

package gaussian_pkg;

  localparam int unsigned PIX_PER_LINE = `GAUSS_LINE_BITS / `GAUSS_PIX_BITS;

  typedef logic [`GAUSS_PIX_BITS-1:0] t_pixel;
  typedef t_pixel [PIX_PER_LINE-1:0]  t_pix_line;    // pixel 0 in the low bits
  typedef logic [15:0]                t_line_count;  // size in lines

  typedef struct packed {
    host_if_pkg::t_line_addr base;
    t_line_count             size;
  } t_buffer_desc;

  typedef struct packed {
    t_buffer_desc            src;
    t_buffer_desc            dst;
    host_if_pkg::t_line_addr status_addr;
  } t_job_desc;

  typedef enum logic [1:0] {
    rd_idle,
    rd_fetch,
    rd_drain
  } t_rd_state;

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_status,
    wr_done
  } t_wr_state;

endpackage : gaussian_pkg

`default_nettype wire

// ==== gaussian_requestor.sv ====
// host memory requestor

`timescale 1ns/1ps
`default_nettype none

`include "gaussian_settings.svh"

module gaussian_requestor (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    go,
  input  gaussian_pkg::t_job_desc job,
  input  host_if_pkg::t_mem_rsp   rsp,
  input  host_if_pkg::t_mem_flow  flow,
  input  host_if_pkg::t_line_data filt_line,
  input  logic                    filt_valid,
  output host_if_pkg::t_rd_req    rd_req,
  output host_if_pkg::t_wr_req    wr_req,
  output host_if_pkg::t_line_data line_out,
  output logic                    line_valid,
  output logic                    done
);

  localparam int unsigned QW = $clog2(`GAUSS_WRQ_DEPTH);

  typedef logic [QW-1:0] t_q_ptr;
  typedef logic [QW:0]   t_q_count;   // also used for read credits

  gaussian_pkg::t_rd_state   rd_state;
  gaussian_pkg::t_wr_state   wr_state;
  gaussian_pkg::t_line_count rd_offset;
  gaussian_pkg::t_line_count wr_offset;
  gaussian_pkg::t_line_count wr_rsp_cnt;

  host_if_pkg::t_line_data q_mem [`GAUSS_WRQ_DEPTH];
  t_q_ptr                  q_wr_ptr;
  t_q_ptr                  q_rd_ptr;
  t_q_count                q_count;
  t_q_count                in_flight;   // reads issued whose line is not yet written

  logic rd_issue;
  logic wr_data_issue;
  logic wr_stat_issue;

  assign rd_issue      = (rd_state == gaussian_pkg::rd_fetch) && !flow.rd_alm_full &&
                         (rd_offset != job.src.size) &&
                         (in_flight < t_q_count'(`GAUSS_WRQ_DEPTH));
  assign wr_data_issue = (wr_state == gaussian_pkg::wr_data) && !flow.wr_alm_full &&
                         (q_count != '0);
  assign wr_stat_issue = (wr_state == gaussian_pkg::wr_status) && !flow.wr_alm_full &&
                         (wr_rsp_cnt == job.src.size);

  // ####################################################################
  // read machine
  // ####################################################################

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state  <= gaussian_pkg::rd_idle;
      rd_offset <= '0;
      rd_req    <= '0;
    end else begin
      rd_req.valid <= rd_issue;
      if (rd_issue) begin
        rd_req.addr <= host_if_pkg::t_line_addr'(job.src.base + rd_offset);
        rd_offset   <= rd_offset + 1'b1;
      end
      case (rd_state)
        gaussian_pkg::rd_idle: begin
          if (go) begin
            rd_offset <= '0;
            rd_state  <= gaussian_pkg::rd_fetch;
          end
        end
        gaussian_pkg::rd_fetch: begin
          if (rd_offset == job.src.size) begin
            rd_state <= gaussian_pkg::rd_drain;
          end
        end
        gaussian_pkg::rd_drain: begin
          if (done) rd_state <= gaussian_pkg::rd_idle;
        end
        default: rd_state <= gaussian_pkg::rd_idle;
      endcase
    end
  end

  // read responses go straight on to the filter
  always_ff @(posedge clk) begin
    if (rsp.valid && rsp.kind == host_if_pkg::rsp_rdline) begin
      line_out <= rsp.data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      line_valid <= 1'b0;
      wr_rsp_cnt <= '0;
    end else begin
      line_valid <= rsp.valid && (rsp.kind == host_if_pkg::rsp_rdline);
      if (go) begin
        wr_rsp_cnt <= '0;
      end else if (rsp.valid && rsp.kind == host_if_pkg::rsp_wrline) begin
        wr_rsp_cnt <= wr_rsp_cnt + 1'b1;
      end
    end
  end

  // ####################################################################
  // write queue and credits
  // ####################################################################

  always_ff @(posedge clk) begin
    if (filt_valid) q_mem[q_wr_ptr] <= filt_line;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      q_wr_ptr  <= '0;
      q_rd_ptr  <= '0;
      q_count   <= '0;
      in_flight <= '0;
    end else begin
      if (filt_valid) q_wr_ptr <= q_wr_ptr + 1'b1;
      if (wr_data_issue) q_rd_ptr <= q_rd_ptr + 1'b1;
      q_count   <= q_count + t_q_count'(filt_valid) - t_q_count'(wr_data_issue);
      in_flight <= in_flight + t_q_count'(rd_issue) - t_q_count'(wr_data_issue);
    end
  end

  // ####################################################################
  // write machine
  // ####################################################################

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state  <= gaussian_pkg::wr_idle;
      wr_offset <= '0;
      wr_req    <= '0;
      done      <= 1'b0;
    end else begin
      wr_req.valid <= wr_data_issue || wr_stat_issue;
      done         <= 1'b0;
      if (wr_data_issue) begin
        wr_req.addr <= host_if_pkg::t_line_addr'(job.dst.base + wr_offset);
        wr_req.data <= q_mem[q_rd_ptr];
        wr_offset   <= wr_offset + 1'b1;
      end
      if (wr_stat_issue) begin
        wr_req.addr <= job.status_addr;
        wr_req.data <= host_if_pkg::t_line_data'(1);   // status value
      end
      case (wr_state)
        gaussian_pkg::wr_idle: begin
          if (go) begin
            wr_offset <= '0;
            wr_state  <= gaussian_pkg::wr_data;
          end
        end
        gaussian_pkg::wr_data: begin
          if (wr_offset == job.src.size) wr_state <= gaussian_pkg::wr_status;
        end
        gaussian_pkg::wr_status: begin
          if (wr_stat_issue) wr_state <= gaussian_pkg::wr_done;
        end
        gaussian_pkg::wr_done: begin
          // wait for the status write response too
          if (wr_rsp_cnt == gaussian_pkg::t_line_count'(job.src.size + 1'b1)) begin
            done     <= 1'b1;
            wr_state <= gaussian_pkg::wr_idle;
          end
        end
        default: wr_state <= gaussian_pkg::wr_idle;
      endcase
    end
  end

endmodule : gaussian_requestor

`default_nettype wire

// ==== gaussian_settings.svh ====
// gaussian blur settings

`ifndef GAUSSIAN_SETTINGS_SVH
`define GAUSSIAN_SETTINGS_SVH

// one memory line and its pixels
`define GAUSS_LINE_BITS   64
`define GAUSS_PIX_BITS    8

// line address on the host channel
`define GAUSS_ADDR_BITS   16

// write queue depth, also the read credit limit
`define GAUSS_WRQ_DEPTH   8

// response latency bounds in cycles
`define GAUSS_RSP_LAT_MIN 2
`define GAUSS_RSP_LAT_MAX 12

`endif

// ==== gaussian_sva.sv ====
// channel and handshake assertions

`timescale 1ns/1ps
`default_nettype none

`include "gaussian_settings.svh"

module gaussian_sva (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start_req,
  input  logic                   start_ack,
  input  logic [1:0]             ctrl_state,
  input  host_if_pkg::t_rd_req   rd_req,
  input  host_if_pkg::t_wr_req   wr_req,
  input  host_if_pkg::t_mem_flow flow
);

  // a valid follows a cycle with almost-full low
  rd_after_full: assert property (@(posedge clk) disable iff (reset)
    rd_req.valid |-> !$past(flow.rd_alm_full))
    else $error("read request issued after rd_alm_full was high");

  wr_after_full: assert property (@(posedge clk) disable iff (reset)
    wr_req.valid |-> !$past(flow.wr_alm_full))
    else $error("write request issued after wr_alm_full was high");

  ack_held: assert property (@(posedge clk) disable iff (reset)
    (start_ack && start_req) |=> start_ack)
    else $error("start_ack fell while start_req was high");

  idle_quiet: assert property (@(posedge clk) disable iff (reset)
    (ctrl_state == 2'd0) |-> (!rd_req.valid && !wr_req.valid))
    else $error("request valid high while job control idle");

endmodule : gaussian_sva

bind gaussian_accel_top gaussian_sva u_sva (
  .clk        (clk),
  .reset      (reset),
  .start_req  (start_req),
  .start_ack  (start_ack),
  .ctrl_state (u_job_ctrl.state),
  .rd_req     (rd_req),
  .wr_req     (wr_req),
  .flow       (flow)
);

`default_nettype wire

// ==== gaussian_tb.sv ====
// gaussian accelerator testbench

`timescale 1ns/1ps
`default_nettype none

`include "gaussian_settings.svh"

module gaussian_tb;

  localparam int CLK_PERIOD  = 100;
  localparam int NPIX        = `GAUSS_LINE_BITS / `GAUSS_PIX_BITS;
  localparam int NLINES      = 1 << `GAUSS_ADDR_BITS;
  localparam int TOTAL_LINES = 4 + 16 + 1 + 1 + 6 + 5;   // all jobs below
  localparam int WDOG_CYCLES = TOTAL_LINES * `GAUSS_RSP_LAT_MAX * 4 + 1000;

  logic                    clk;
  logic                    reset;
  logic                    start_req;
  logic                    start_ack;
  logic                    random_flow;
  gaussian_pkg::t_job_desc job_in;
  host_if_pkg::t_mem_rsp   rsp;
  host_if_pkg::t_mem_flow  flow;
  host_if_pkg::t_rd_req    rd_req;
  host_if_pkg::t_wr_req    wr_req;

  int checks;
  int value_errors;
  int other_errors;

  gaussian_accel_top DUT (
    .clk       (clk),
    .reset     (reset),
    .start_req (start_req),
    .job_in    (job_in),
    .rsp       (rsp),
    .flow      (flow),
    .start_ack (start_ack),
    .rd_req    (rd_req),
    .wr_req    (wr_req)
  );

  host_mem_model MEM (
    .clk         (clk),
    .reset       (reset),
    .random_flow (random_flow),
    .rd_req      (rd_req),
    .wr_req      (wr_req),
    .rsp         (rsp),
    .flow        (flow)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ####################################################################
  // compare tasks and reference rule
  // ####################################################################

  task automatic check_line(input string name, input host_if_pkg::t_line_data exp,
                            input host_if_pkg::t_line_data act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input host_if_pkg::t_line_addr exp,
                            input host_if_pkg::t_line_addr act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // 1-2-1 with edge replication, then a plain shift by two
  function automatic host_if_pkg::t_line_data blur_rule(input host_if_pkg::t_line_data src);
    int                      p [NPIX];
    int                      s;
    host_if_pkg::t_line_data res;
    res = '0;
    for (int i = 0; i < NPIX; i++) p[i] = src[i*`GAUSS_PIX_BITS +: `GAUSS_PIX_BITS];
    for (int i = 0; i < NPIX; i++) begin
      s = (p[(i == 0) ? 0 : i - 1] + 2 * p[i] + p[(i == NPIX - 1) ? i : i + 1]) >> 2;
      res[i*`GAUSS_PIX_BITS +: `GAUSS_PIX_BITS] = s[`GAUSS_PIX_BITS-1:0];
    end
    return res;
  endfunction

  function automatic gaussian_pkg::t_job_desc make_job(input int src, input int dst,
                                                       input int stat, input int n);
    gaussian_pkg::t_job_desc jd;
    jd.src.base    = host_if_pkg::t_line_addr'(src);
    jd.src.size    = gaussian_pkg::t_line_count'(n);
    jd.dst.base    = host_if_pkg::t_line_addr'(dst);
    jd.dst.size    = gaussian_pkg::t_line_count'(n);
    jd.status_addr = host_if_pkg::t_line_addr'(stat);
    return jd;
  endfunction

  task automatic fill_random(input int base, input int n);
    for (int i = 0; i < n; i++) MEM.lines[(base + i) % NLINES] = {$urandom, $urandom};
  endtask

  // ####################################################################
  // job runner
  // ####################################################################

  task automatic run_job(input gaussian_pkg::t_job_desc jd, input logic rand_flow);
    host_if_pkg::t_line_data exp_q [$];
    int                      total;
    int                      a;
    for (int i = 0; i < jd.src.size; i++) exp_q.push_back(blur_rule(MEM.lines[jd.src.base + i]));
    for (int i = 0; i < NLINES; i++) MEM.wr_hits[i] = 0;
    @(posedge clk);
    job_in      <= jd;
    random_flow <= rand_flow;
    start_req   <= 1'b1;
    repeat (2) @(posedge clk);
    job_in <= ~jd;                     // host moves on, the job must keep its descriptor
    do @(posedge clk); while (start_ack !== 1'b1);
    repeat (3) begin                   // host is slow to drop its request
      @(posedge clk);
      check_flag("start_ack", 1'b1, start_ack);
    end
    for (int i = 0; i < jd.src.size; i++) begin
      a = (jd.dst.base + i) % NLINES;
      check_line($sformatf("dst line %0d", i), exp_q[i], MEM.lines[a]);
      if (MEM.wr_hits[a] != 1) begin
        other_errors++;
        $display("destination line %h was written %0d times", a, MEM.wr_hits[a]);
      end
    end
    check_line("status line", host_if_pkg::t_line_data'(1), MEM.lines[jd.status_addr]);
    check_addr("wr_req.addr of last write", jd.status_addr, MEM.last_wr_addr);
    total = 0;
    for (int i = 0; i < NLINES; i++) total += MEM.wr_hits[i];
    if (total != jd.src.size + 1) begin
      other_errors++;
      $display("%0d writes seen, some fell outside the destination and status", total);
    end
    start_req <= 1'b0;
    do @(posedge clk); while (start_ack !== 1'b0);
    random_flow <= 1'b0;
  endtask

  // ####################################################################
  // directed tests
  // ####################################################################

  task automatic test_reset_state();
    @(posedge clk);
    check_flag("rd_req.valid", 1'b0, rd_req.valid);
    check_flag("wr_req.valid", 1'b0, wr_req.valid);
    check_flag("start_ack", 1'b0, start_ack);
  endtask

  task automatic test_four_lines();
    fill_random(16'h0100, 4);
    run_job(make_job(16'h0100, 16'h0200, 16'h0300, 4), 1'b0);
  endtask

  task automatic test_backpressure();
    fill_random(16'h1000, 16);
    run_job(make_job(16'h1000, 16'h2000, 16'h2fff, 16), 1'b1);
  endtask

  task automatic test_edge_lines();
    MEM.lines[16'h0400] = 64'hffff_ffff_ffff_ffff;   // saturation
    run_job(make_job(16'h0400, 16'h0500, 16'h0600, 1), 1'b0);
    MEM.lines[16'h0410] = 64'hff00_ff00_ff00_ff00;   // pixel 0 is zero
    run_job(make_job(16'h0410, 16'h0510, 16'h0610, 1), 1'b0);
  endtask

  task automatic test_back_to_back();
    fill_random(16'h3000, 6);
    fill_random(16'h5000, 5);
    run_job(make_job(16'h3000, 16'h4000, 16'h4800, 6), 1'b0);
    run_job(make_job(16'h5000, 16'h6000, 16'h6800, 5), 1'b1);
  endtask

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, a job never finished", WDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hd5c5));
    clk          = 1'b0;
    reset        = 1'b1;
    start_req    = 1'b0;
    random_flow  = 1'b0;
    job_in       = '0;
    checks       = 0;
    value_errors = 0;
    other_errors = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_four_lines();
    test_backpressure();
    test_edge_lines();
    test_back_to_back();
    $display("summary %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : gaussian_tb

`default_nettype wire

// ==== host_if_pkg.sv ====
// host memory channel types

`default_nettype none

`include "gaussian_settings.svh"

package host_if_pkg;

  typedef logic [`GAUSS_ADDR_BITS-1:0] t_line_addr;   // line address
  typedef logic [`GAUSS_LINE_BITS-1:0] t_line_data;   // one memory line

  typedef enum logic {
    rsp_rdline,
    rsp_wrline
  } t_rsp_kind;

  // read request channel
  typedef struct packed {
    logic       valid;
    t_line_addr addr;
  } t_rd_req;

  // write request channel
  typedef struct packed {
    logic       valid;
    t_line_addr addr;
    t_line_data data;
  } t_wr_req;

  // shared response channel, data only for reads
  typedef struct packed {
    logic       valid;
    t_rsp_kind  kind;
    t_line_data data;
  } t_mem_rsp;

  typedef struct packed {
    logic rd_alm_full;
    logic wr_alm_full;
  } t_mem_flow;

endpackage : host_if_pkg

`default_nettype wire

// ==== host_mem_model.sv ====
// host memory model

`timescale 1ns/1ps
`default_nettype none

`include "gaussian_settings.svh"

module host_mem_model (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   random_flow,
  input  host_if_pkg::t_rd_req   rd_req,
  input  host_if_pkg::t_wr_req   wr_req,
  output host_if_pkg::t_mem_rsp  rsp,
  output host_if_pkg::t_mem_flow flow
);

  localparam int unsigned NLINES = 1 << `GAUSS_ADDR_BITS;

  host_if_pkg::t_line_data lines [NLINES];
  int unsigned             wr_hits [NLINES];   // writes seen per line address
  host_if_pkg::t_line_addr last_wr_addr;
  host_if_pkg::t_mem_rsp   pend_rsp [$];
  longint unsigned         pend_due [$];
  longint unsigned         cycle;
  longint unsigned         last_due;

  // background pattern over the whole address
  initial begin
    for (int a = 0; a < NLINES; a++) begin
      host_if_pkg::t_line_addr ad;
      ad = host_if_pkg::t_line_addr'(a);
      lines[a] = {~ad, ad ^ 16'hc3c3, ad, ad ^ 16'h5a5a};
    end
  end

  task automatic push_rsp(input host_if_pkg::t_rsp_kind kind,
                          input host_if_pkg::t_line_data data);
    host_if_pkg::t_mem_rsp r;
    longint unsigned       due;
    r.valid = 1'b1;
    r.kind  = kind;
    r.data  = data;
    due     = cycle + $urandom_range(`GAUSS_RSP_LAT_MAX, `GAUSS_RSP_LAT_MIN);
    if (due <= last_due) due = last_due + 1;   // in order, one per cycle
    last_due = due;
    pend_rsp.push_back(r);
    pend_due.push_back(due);
  endtask

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      rsp      <= '0;
      flow     <= '0;
      cycle    = 0;
      last_due = 0;
      pend_rsp.delete();
      pend_due.delete();
    end else begin
      cycle = cycle + 1;
      if (rd_req.valid) push_rsp(host_if_pkg::rsp_rdline, lines[rd_req.addr]);
      if (wr_req.valid) begin
        lines[wr_req.addr]   = wr_req.data;
        wr_hits[wr_req.addr] = wr_hits[wr_req.addr] + 1;
        last_wr_addr         = wr_req.addr;
        push_rsp(host_if_pkg::rsp_wrline, '0);
      end
      if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
        rsp <= pend_rsp.pop_front();
        void'(pend_due.pop_front());
      end else begin
        rsp <= '0;
      end
      if (random_flow) begin
        flow.rd_alm_full <= ($urandom_range(2) == 0);   // about one cycle in three
        flow.wr_alm_full <= ($urandom_range(2) == 0);
      end else begin
        flow <= '0;
      end
    end
  end

endmodule : host_mem_model

`default_nettype wire

// ==== sim.f ====
+incdir+.
host_if_pkg.sv
gaussian_pkg.sv
gaussian_job_ctrl.sv
gaussian_line_filter.sv
gaussian_requestor.sv
gaussian_accel_top.sv
host_mem_model.sv
gaussian_sva.sv
gaussian_tb.sv
